// File: build.f
+incdir+design
design/bus_pkg.sv
design/clint.sv
design/mem_bus.sv
design/axi_sram.sv
design/soc_bus_top.sv
testbench/tb_soc_bus.sv

// File: run.sh
#!/bin/sh
# compile and run the bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_soc_bus \
  -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: testbench/tb_soc_bus.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module tb_soc_bus;

  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;
  localparam logic [31:0] RAM_BASE = 32'h8000_0000;

  logic                   clock = 1'b0;
  logic                   reset;
  logic                   flush_pipe;
  logic                   ifu_arvalid;
  logic [`BUS_XLEN-1:0]   ifu_araddr;
  logic                   ifu_bus_ready;
  logic                   ifu_rvalid;
  logic [`BUS_XLEN-1:0]   ifu_rdata;
  logic                   lsu_arvalid;
  logic [`BUS_XLEN-1:0]   lsu_araddr;
  logic [`BUS_XLEN/8-1:0] lsu_rstrb;
  logic                   lsu_rvalid;
  logic [`BUS_XLEN-1:0]   lsu_rdata;
  logic                   lsu_awvalid;
  logic [`BUS_XLEN-1:0]   lsu_awaddr;
  logic                   lsu_wvalid;
  logic [`BUS_XLEN-1:0]   lsu_wdata;
  logic [`BUS_XLEN/8-1:0] lsu_wstrb;
  logic                   lsu_wready;

  logic [31:0] model [0:`BUS_SRAM_WORDS-1]; // expected sram contents
  int unsigned cycle_cnt = 0;

  soc_bus_top dut (.*);

  always #20 clock = ~clock;

  always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value check failed");
    end
  endtask

  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[31:2] % `BUS_SRAM_WORDS);
  endfunction

  // lane b takes data byte b-off when its strobe bit is set
  task automatic model_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int idx;
    int off;
    idx = word_index(addr);
    off = int'(addr[1:0]);
    for (int b = 0; b < 4; b++) begin
      if (b >= off && strb[b - off]) model[idx][8*b +: 8] = data[8*(b - off) +: 8];
    end
  endtask

  task automatic lsu_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(posedge clock);
    lsu_awvalid <= 1'b1;
    lsu_wvalid  <= 1'b1;
    lsu_awaddr  <= addr;
    lsu_wdata   <= data;
    lsu_wstrb   <= strb;
    @(negedge clock);
    while (!lsu_wready) @(negedge clock);
    @(posedge clock);
    lsu_awvalid <= 1'b0;
    lsu_wvalid  <= 1'b0;
    model_store(addr, data, strb);
  endtask

  task automatic lsu_load(input logic [31:0] addr, output logic [31:0] data,
                          output int unsigned at);
    @(posedge clock);
    lsu_arvalid <= 1'b1;
    lsu_araddr  <= addr;
    lsu_rstrb   <= 4'hf;
    @(negedge clock);
    while (!lsu_rvalid) @(negedge clock);
    data = lsu_rdata;
    at   = cycle_cnt;
    @(posedge clock);
    lsu_arvalid <= 1'b0;
  endtask

  task automatic ifu_fetch(input logic [31:0] addr, output int beats,
                           output logic [31:0] word0, output logic [31:0] word1,
                           output int unsigned first_at);
    beats    = 0;
    word0    = '0;
    word1    = '0;
    first_at = 0;
    @(posedge clock);
    ifu_arvalid <= 1'b1;
    ifu_araddr  <= addr;
    @(negedge clock);
    while (!ifu_bus_ready) @(negedge clock);
    @(posedge clock);
    ifu_arvalid <= 1'b0; // bridge took it at this edge
    @(negedge clock);
    while (!ifu_bus_ready) begin
      if (ifu_rvalid) begin
        if (beats == 0) begin
          word0    = ifu_rdata;
          first_at = cycle_cnt;
        end else begin
          word1 = ifu_rdata;
        end
        beats++;
      end
      @(negedge clock);
    end
  endtask

  task automatic test_word_rw;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] got;
    int unsigned at;
    for (int i = 0; i < 8; i++) begin
      addr = RAM_BASE | ($urandom & 32'h0000_0ffc);
      data = $urandom;
      lsu_store(addr, data, 4'hf);
      lsu_load(addr, got, at);
      check_eq(got, data, "word load after word store");
    end
  endtask

  task automatic test_byte_half;
    logic [31:0] base;
    logic [31:0] got;
    int unsigned at;
    base = RAM_BASE | ($urandom & 32'h0000_0ffc);
    lsu_store(base, $urandom, 4'hf);
    for (int off = 0; off < 4; off++) begin
      lsu_store(base + 32'(off), $urandom, 4'h1);
      lsu_load(base, got, at);
      check_eq(got, model[word_index(base)], "word load after byte store");
      lsu_store(base + 32'(off), $urandom, 4'h3);
      lsu_load(base, got, at);
      check_eq(got, model[word_index(base)], "word load after half store");
    end
  endtask

  task automatic test_fetch_burst;
    logic [31:0] addr;
    logic [31:0] d0;
    logic [31:0] d1;
    int beats;
    int unsigned at;
    addr = `BUS_BURST_BASE + ($urandom & 32'h0000_07f8);
    lsu_store(addr, $urandom, 4'hf);
    lsu_store(addr + 32'd4, $urandom, 4'hf);
    ifu_fetch(addr, beats, d0, d1, at);
    check_eq(beats, 32'd2, "fetch beats inside burst region");
    check_eq(d0, model[word_index(addr)], "first burst beat");
    check_eq(d1, model[word_index(addr + 32'd4)], "second burst beat");
    addr = `BUS_BURST_TOP + 32'd1 + ($urandom & 32'h0000_07fc);
    lsu_store(addr, $urandom, 4'hf);
    ifu_fetch(addr, beats, d0, d1, at);
    check_eq(beats, 32'd1, "fetch beats outside burst region");
    check_eq(d0, model[word_index(addr)], "single fetch beat");
  endtask

  task automatic test_arbitration;
    logic [31:0] iaddr;
    logic [31:0] laddr;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] got;
    int beats;
    int unsigned ifu_at;
    int unsigned lsu_at;
    iaddr = `BUS_BURST_TOP + 32'd1 + ($urandom & 32'h0000_07fc);
    laddr = RAM_BASE | ($urandom & 32'h0000_0ffc);
    lsu_store(iaddr, $urandom, 4'hf);
    lsu_store(laddr, $urandom, 4'hf);
    fork // both requests on the same edge
      ifu_fetch(iaddr, beats, d0, d1, ifu_at);
      lsu_load(laddr, got, lsu_at);
    join
    check_eq(32'(ifu_at < lsu_at), 32'd1, "fetch beat arrives before load data");
    check_eq(beats, 32'd1, "fetch beats during arbitration");
    check_eq(d0, model[word_index(iaddr)], "fetch data during arbitration");
    check_eq(got, model[word_index(laddr)], "load data during arbitration");
  endtask

  task automatic test_flush;
    logic [31:0] addr;
    logic [31:0] got;
    int unsigned at;
    addr = RAM_BASE | ($urandom & 32'h0000_0ffc);
    lsu_store(addr, $urandom, 4'hf);
    @(posedge clock);
    lsu_arvalid <= 1'b1;
    lsu_araddr  <= addr;
    lsu_rstrb   <= 4'hf;
    @(posedge clock);
    flush_pipe <= 1'b1;
    @(negedge clock);
    check_eq(32'(ifu_bus_ready), 32'd0, "bridge busy with the load");
    @(posedge clock);
    lsu_arvalid <= 1'b0;
    flush_pipe  <= 1'b0;
    @(negedge clock);
    while (!ifu_bus_ready) begin
      check_eq(32'(lsu_rvalid), 32'd0, "lsu_rvalid for a flushed load");
      @(negedge clock);
    end
    lsu_load(addr, got, at);
    check_eq(got, model[word_index(addr)], "load after flush");
  endtask

  task automatic test_timer;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] hi;
    int unsigned at0;
    int unsigned at1;
    lsu_load(`BUS_CLINT_ADDR, t0, at0);
    repeat (5 + $urandom % 20) @(posedge clock);
    lsu_load(`BUS_CLINT_ADDR, t1, at1);
    check_eq(t1 - t0, at1 - at0, "timer delta against cycle count");
    lsu_load(`BUS_CLINT_ADDR_UP, hi, at0);
    check_eq(hi, 32'd0, "timer high word");
  endtask

  initial begin
    void'($urandom(32'h5b7d_5cac));
    reset       = 1'b1;
    flush_pipe  = 1'b0;
    ifu_arvalid = 1'b0;
    ifu_araddr  = '0;
    lsu_arvalid = 1'b0;
    lsu_araddr  = '0;
    lsu_rstrb   = '0;
    lsu_awvalid = 1'b0;
    lsu_awaddr  = '0;
    lsu_wvalid  = 1'b0;
    lsu_wdata   = '0;
    lsu_wstrb   = '0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    test_word_rw();
    test_byte_half();
    test_fetch_burst();
    test_arbitration();
    test_flush();
    test_timer();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: design/soc_bus_top.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module soc_bus_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   flush_pipe,
  // IFU
  input  logic                   ifu_arvalid,
  input  logic [`BUS_XLEN-1:0]   ifu_araddr,
  output logic                   ifu_bus_ready,
  output logic                   ifu_rvalid,
  output logic [`BUS_XLEN-1:0]   ifu_rdata,
  // LSU
  input  logic                   lsu_arvalid,
  input  logic [`BUS_XLEN-1:0]   lsu_araddr,
  input  logic [`BUS_XLEN/8-1:0] lsu_rstrb,
  output logic                   lsu_rvalid,
  output logic [`BUS_XLEN-1:0]   lsu_rdata,
  input  logic                   lsu_awvalid,
  input  logic [`BUS_XLEN-1:0]   lsu_awaddr,
  input  logic                   lsu_wvalid,
  input  logic [`BUS_XLEN-1:0]   lsu_wdata,
  input  logic [`BUS_XLEN/8-1:0] lsu_wstrb,
  output logic                   lsu_wready
);

  logic                   clint_arvalid;
  logic                   clint_rvalid;
  logic [`BUS_XLEN-1:0]   clint_rdata;

  logic                   axi_arvalid;
  logic                   axi_arready;
  logic [`BUS_XLEN-1:0]   axi_araddr;
  logic [7:0]             axi_arlen;
  bus_pkg::access_size_t  axi_arsize;
  bus_pkg::burst_t        axi_arburst;
  logic                   axi_rvalid;
  logic                   axi_rready;
  logic                   axi_rlast;
  logic [`BUS_XLEN-1:0]   axi_rdata;
  bus_pkg::axi_resp_t     axi_rresp;
  logic                   axi_awvalid;
  logic                   axi_awready;
  logic [`BUS_XLEN-1:0]   axi_awaddr;
  bus_pkg::access_size_t  axi_awsize;
  logic                   axi_wvalid;
  logic                   axi_wready;
  logic                   axi_wlast;
  logic [`BUS_XLEN-1:0]   axi_wdata;
  logic [`BUS_XLEN/8-1:0] axi_wstrb;
  logic                   axi_bvalid;
  logic                   axi_bready;
  bus_pkg::axi_resp_t     axi_bresp;

  mem_bus u_mem_bus (.*);

  // timer sees the held load address
  clint u_clint (
    .clock  (clock),
    .reset  (reset),
    .araddr (lsu_araddr),
    .arvalid(clint_arvalid),
    .rvalid (clint_rvalid),
    .rdata  (clint_rdata)
  );

  axi_sram u_sram (
    .clock  (clock),
    .reset  (reset),
    .arvalid(axi_arvalid),
    .araddr (axi_araddr),
    .arlen  (axi_arlen),
    .arsize (axi_arsize),
    .arburst(axi_arburst),
    .arready(axi_arready),
    .rvalid (axi_rvalid),
    .rdata  (axi_rdata),
    .rresp  (axi_rresp),
    .rlast  (axi_rlast),
    .rready (axi_rready),
    .awvalid(axi_awvalid),
    .awaddr (axi_awaddr),
    .awsize (axi_awsize),
    .wvalid (axi_wvalid),
    .wdata  (axi_wdata),
    .wstrb  (axi_wstrb),
    .wlast  (axi_wlast),
    .awready(axi_awready),
    .wready (axi_wready),
    .bvalid (axi_bvalid),
    .bresp  (axi_bresp),
    .bready (axi_bready)
  );

endmodule

// File: design/axi_sram.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module axi_sram (
  input  logic                   clock,
  input  logic                   reset,
  // read address
  input  logic                   arvalid,
  input  logic [`BUS_XLEN-1:0]   araddr,
  input  logic [7:0]             arlen,
  input  bus_pkg::access_size_t  arsize,
  input  bus_pkg::burst_t        arburst,
  output logic                   arready,
  // read data
  output logic                   rvalid,
  output logic [`BUS_XLEN-1:0]   rdata,
  output bus_pkg::axi_resp_t     rresp,
  output logic                   rlast,
  input  logic                   rready,
  // write address and data
  input  logic                   awvalid,
  input  logic [`BUS_XLEN-1:0]   awaddr,
  input  bus_pkg::access_size_t  awsize,
  input  logic                   wvalid,
  input  logic [`BUS_XLEN-1:0]   wdata,
  input  logic [`BUS_XLEN/8-1:0] wstrb,
  input  logic                   wlast,
  output logic                   awready,
  output logic                   wready,
  // write response
  output logic                   bvalid,
  output bus_pkg::axi_resp_t     bresp,
  input  logic                   bready
);

  localparam int AW = $clog2(`BUS_SRAM_WORDS);

  logic [`BUS_XLEN-1:0] mem [0:`BUS_SRAM_WORDS-1];

  logic          rd_active;
  logic          rd_left;   // second beat still owed
  logic [3:0]    rd_cnt;
  logic [AW-1:0] rd_idx;
  logic          rd_incr;
  logic          ar_take;
  logic          rd_fire;
  logic          r_take;

  assign arready = !rd_active;
  assign ar_take = arvalid && arready;
  assign rd_fire = rd_active && !rvalid && (rd_cnt == 4'd0);
  assign r_take  = rvalid && rready;
  assign rresp   = bus_pkg::RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_active <= 1'b0;
      rd_left   <= 1'b0;
      rd_cnt    <= 4'd0;
      rvalid    <= 1'b0;
    end else begin
      if (ar_take) begin
        rd_active <= 1'b1;
        rd_left   <= arlen[0];
        rd_cnt    <= 4'(`BUS_SRAM_LATENCY - 2);
      end else if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rd_active && !rvalid) begin
        rd_cnt <= rd_cnt - 4'd1;
      end
      if (r_take) begin
        if (rd_left) begin
          rd_left <= 1'b0;
        end else begin
          rvalid    <= 1'b0;
          rd_active <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_take) begin
      rd_idx  <= araddr[AW+1:2];
      rd_incr <= (arburst == bus_pkg::BURST_INCR);
    end
    if (rd_fire) begin
      rdata <= mem[rd_idx];
      rlast <= !rd_left;
    end else if (r_take && rd_left) begin
      rdata <= rd_incr ? mem[rd_idx + AW'(1)] : mem[rd_idx]; // wraps with depth
      rlast <= 1'b1;
    end
  end

  logic                   aw_got;
  logic                   w_got;
  logic                   aw_take;
  logic                   w_take;
  logic                   wr_go;
  logic [AW-1:0]          wr_idx;
  logic [`BUS_XLEN-1:0]   wr_data;
  logic [`BUS_XLEN/8-1:0] wr_strb;
  logic [AW-1:0]          idx_now;
  logic [`BUS_XLEN-1:0]   data_now;
  logic [`BUS_XLEN/8-1:0] strb_now;

  assign awready  = !aw_got && !bvalid;
  assign wready   = !w_got && !bvalid;
  assign aw_take  = awvalid && awready;
  assign w_take   = wvalid && wready;
  assign wr_go    = (aw_got || aw_take) && (w_got || w_take);
  assign idx_now  = aw_got ? wr_idx : awaddr[AW+1:2];
  assign data_now = w_got ? wr_data : wdata;
  assign strb_now = w_got ? wr_strb : wstrb;
  assign bresp    = bus_pkg::RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_got <= 1'b0;
      w_got  <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (bvalid && bready) bvalid <= 1'b0;
      if (wr_go) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bvalid <= 1'b1;
      end else begin
        if (aw_take) aw_got <= 1'b1;
        if (w_take) w_got <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_take) wr_idx <= awaddr[AW+1:2];
    if (w_take) begin
      wr_data <= wdata;
      wr_strb <= wstrb;
    end
    if (wr_go) begin
      for (int b = 0; b < `BUS_XLEN/8; b++) begin
        if (strb_now[b]) mem[idx_now][8*b +: 8] <= data_now[8*b +: 8];
      end
    end
  end

  // bursts of two beats at most
  a_ar_len: assert property (@(posedge clock) disable iff (reset)
    arvalid |-> arlen <= 8'd1 && arsize <= bus_pkg::SIZE_WORD);

  a_w_single: assert property (@(posedge clock) disable iff (reset)
    wvalid |-> wlast && (!awvalid || awsize <= bus_pkg::SIZE_WORD));

endmodule

// File: design/mem_bus.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module mem_bus (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush_pipe,
  // IFU
  input  logic                     ifu_arvalid,
  input  logic [`BUS_XLEN-1:0]     ifu_araddr,
  output logic                     ifu_bus_ready,
  output logic                     ifu_rvalid,
  output logic [`BUS_XLEN-1:0]     ifu_rdata,
  // LSU reads
  input  logic                     lsu_arvalid,
  input  logic [`BUS_XLEN-1:0]     lsu_araddr,
  input  logic [`BUS_XLEN/8-1:0]   lsu_rstrb,
  output logic                     lsu_rvalid,
  output logic [`BUS_XLEN-1:0]     lsu_rdata,
  // LSU writes
  input  logic                     lsu_awvalid,
  input  logic [`BUS_XLEN-1:0]     lsu_awaddr,
  input  logic                     lsu_wvalid,
  input  logic [`BUS_XLEN-1:0]     lsu_wdata,
  input  logic [`BUS_XLEN/8-1:0]   lsu_wstrb,
  output logic                     lsu_wready,
  // CLINT
  output logic                     clint_arvalid,
  input  logic                     clint_rvalid,
  input  logic [`BUS_XLEN-1:0]     clint_rdata,
  // AXI read address
  output logic                     axi_arvalid,
  output logic [`BUS_XLEN-1:0]     axi_araddr,
  output logic [7:0]               axi_arlen,
  output bus_pkg::access_size_t    axi_arsize,
  output bus_pkg::burst_t          axi_arburst,
  input  logic                     axi_arready,
  // AXI read data
  input  logic                     axi_rvalid,
  input  logic [`BUS_XLEN-1:0]     axi_rdata,
  input  bus_pkg::axi_resp_t       axi_rresp,
  input  logic                     axi_rlast,
  output logic                     axi_rready,
  // AXI write address
  output logic                     axi_awvalid,
  output logic [`BUS_XLEN-1:0]     axi_awaddr,
  output bus_pkg::access_size_t    axi_awsize,
  input  logic                     axi_awready,
  // AXI write data
  output logic                     axi_wvalid,
  output logic [`BUS_XLEN-1:0]     axi_wdata,
  output logic [`BUS_XLEN/8-1:0]   axi_wstrb,
  output logic                     axi_wlast,
  input  logic                     axi_wready,
  // AXI write response
  input  logic                     axi_bvalid,
  input  bus_pkg::axi_resp_t       axi_bresp,
  output logic                     axi_bready
);

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_IF_ADDR,
    RD_IF_DATA,
    RD_LS_ADDR,
    RD_LS_ADDR_FL,
    RD_LS_DATA,
    RD_LS_DATA_FL,
    RD_CLINT
  } rd_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_REQ,
    WR_RESP
  } wr_state_t;

  function automatic bus_pkg::access_size_t strb_size(input logic [`BUS_XLEN/8-1:0] strb);
    case (strb)
      'h1:     return bus_pkg::SIZE_BYTE;
      'h3:     return bus_pkg::SIZE_HALF;
      default: return bus_pkg::SIZE_WORD;
    endcase
  endfunction

  rd_state_t             rd_state;
  logic [`BUS_XLEN-1:0]  rd_addr;
  bus_pkg::access_size_t rd_size;
  logic                  rd_burst;
  logic                  ifu_in_burst;
  logic                  lsu_is_timer;
  logic                  r_last_beat;

  assign ifu_in_burst = (`BUS_IFU_BURST != 0) &&
                        (ifu_araddr >= `BUS_BURST_BASE) && (ifu_araddr <= `BUS_BURST_TOP);
  assign lsu_is_timer = (lsu_araddr == `BUS_CLINT_ADDR) || (lsu_araddr == `BUS_CLINT_ADDR_UP);
  assign r_last_beat  = axi_rvalid && axi_rlast;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (ifu_arvalid) begin // fetch wins
            rd_state <= RD_IF_ADDR;
          end else if (lsu_arvalid && !flush_pipe) begin
            rd_state <= lsu_is_timer ? RD_CLINT : RD_LS_ADDR;
          end
        end
        RD_IF_ADDR: if (axi_arready) rd_state <= RD_IF_DATA;
        RD_IF_DATA: if (r_last_beat) rd_state <= RD_IDLE;
        RD_LS_ADDR: begin
          if (flush_pipe) begin
            rd_state <= axi_arready ? RD_LS_DATA_FL : RD_LS_ADDR_FL;
          end else if (axi_arready) begin
            rd_state <= RD_LS_DATA;
          end
        end
        RD_LS_ADDR_FL: if (axi_arready) rd_state <= RD_LS_DATA_FL;
        RD_LS_DATA: begin
          if (r_last_beat) begin
            rd_state <= RD_IDLE;
          end else if (flush_pipe) begin
            rd_state <= RD_LS_DATA_FL;
          end
        end
        // drain the cancelled beat
        RD_LS_DATA_FL: if (r_last_beat) rd_state <= RD_IDLE;
        RD_CLINT: if (clint_rvalid || flush_pipe) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // request captured while idle
  always_ff @(posedge clock) begin
    if (rd_state == RD_IDLE) begin
      if (ifu_arvalid) begin
        rd_addr  <= ifu_araddr;
        rd_size  <= bus_pkg::SIZE_WORD;
        rd_burst <= ifu_in_burst;
      end else begin
        rd_addr  <= lsu_araddr;
        rd_size  <= strb_size(lsu_rstrb);
        rd_burst <= 1'b0;
      end
    end
  end

  assign ifu_bus_ready = (rd_state == RD_IDLE);
  assign ifu_rvalid    = (rd_state == RD_IF_DATA) && axi_rvalid;
  assign ifu_rdata     = axi_rdata;

  assign clint_arvalid = (rd_state == RD_CLINT);
  assign lsu_rvalid    = ((rd_state == RD_LS_DATA) && axi_rvalid) ||
                         ((rd_state == RD_CLINT) && clint_rvalid);
  assign lsu_rdata     = (rd_state == RD_CLINT) ? clint_rdata : axi_rdata;

  assign axi_arvalid = (rd_state == RD_IF_ADDR) || (rd_state == RD_LS_ADDR) ||
                       (rd_state == RD_LS_ADDR_FL);
  assign axi_araddr  = rd_addr;
  assign axi_arlen   = rd_burst ? 8'd1 : 8'd0;
  assign axi_arsize  = rd_size;
  assign axi_arburst = rd_burst ? bus_pkg::BURST_INCR : bus_pkg::BURST_FIXED;
  assign axi_rready  = (rd_state == RD_IF_DATA) || (rd_state == RD_LS_DATA) ||
                       (rd_state == RD_LS_DATA_FL);

  wr_state_t             wr_state;
  logic                  aw_pend;
  logic                  w_pend;
  logic                  aw_done;
  logic                  w_done;
  logic [`BUS_XLEN-1:0]  wr_addr;
  logic [`BUS_XLEN-1:0]  wr_data;
  logic [`BUS_XLEN/8-1:0] wr_strb;
  bus_pkg::access_size_t wr_size;

  assign aw_done = axi_awvalid && axi_awready;
  assign w_done  = axi_wvalid && axi_wready;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_state <= WR_IDLE;
      aw_pend  <= 1'b0;
      w_pend   <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (lsu_awvalid && lsu_wvalid) begin
            wr_state <= WR_REQ;
            aw_pend  <= 1'b1;
            w_pend   <= 1'b1;
          end
        end
        WR_REQ: begin
          if (aw_done) aw_pend <= 1'b0;
          if (w_done) w_pend <= 1'b0;
          if ((aw_done || !aw_pend) && (w_done || !w_pend)) wr_state <= WR_RESP;
        end
        WR_RESP: if (axi_bvalid) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // move the store onto its byte lanes
  always_ff @(posedge clock) begin
    if (wr_state == WR_IDLE) begin
      wr_addr <= lsu_awaddr;
      wr_data <= lsu_wdata << {lsu_awaddr[1:0], 3'b000};
      wr_strb <= lsu_wstrb << lsu_awaddr[1:0];
      wr_size <= strb_size(lsu_wstrb);
    end
  end

  assign axi_awvalid = aw_pend;
  assign axi_awaddr  = wr_addr;
  assign axi_awsize  = wr_size;
  assign axi_wvalid  = w_pend;
  assign axi_wdata   = wr_data;
  assign axi_wstrb   = wr_strb;
  assign axi_wlast   = 1'b1; // single-beat stores
  assign axi_bready  = (wr_state == WR_RESP);
  assign lsu_wready  = axi_bvalid && axi_bready;

  a_rresp_okay: assert property (@(posedge clock) disable iff (reset)
    axi_rvalid |-> axi_rresp == bus_pkg::RESP_OKAY);

  a_bresp_okay: assert property (@(posedge clock) disable iff (reset)
    axi_bvalid |-> axi_bresp == bus_pkg::RESP_OKAY);

  // address must wait for the slave
  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr));

endmodule

// File: design/clint.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module clint (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [`BUS_XLEN-1:0] araddr,
  input  logic                 arvalid,
  output logic                 rvalid,
  output logic [`BUS_XLEN-1:0] rdata
);

  logic [63:0] mtime;
  logic        served; // request already answered

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime  <= 64'd0;
      rvalid <= 1'b0;
      served <= 1'b0;
    end else begin
      mtime  <= mtime + 64'd1;
      rvalid <= arvalid && !served;
      served <= arvalid;
    end
  end

  // sample at the request edge
  always_ff @(posedge clock) begin
    if (arvalid && !served) begin
      rdata <= (araddr == `BUS_CLINT_ADDR_UP) ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

// File: design/bus_pkg.sv
package bus_pkg;

  // AXI size codes
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd0,
    SIZE_HALF = 3'd1,
    SIZE_WORD = 3'd2
  } access_size_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01
  } burst_t;

endpackage

// File: design/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

`define BUS_XLEN 32

// machine timer words
`define BUS_CLINT_ADDR    32'h0200_bff8
`define BUS_CLINT_ADDR_UP 32'h0200_bffc

// two-beat instruction fetch region
`define BUS_IFU_BURST  1
`define BUS_BURST_BASE 32'h8000_0000
`define BUS_BURST_TOP  32'h8000_07ff

`define BUS_SRAM_WORDS   1024
`define BUS_SRAM_LATENCY 2 // two or more

`endif
